//--- source/axi_wr_pkg.sv
`default_nettype none

package axi_wr_pkg;

  // AXI field widths
  localparam int LEN_WIDTH   = 8;
  localparam int SIZE_WIDTH  = 3;
  localparam int BURST_WIDTH = 2;
  localparam int RESP_WIDTH  = 2;

  // burst types, WRAP is not supported
  localparam logic [BURST_WIDTH-1:0] BURST_FIXED = 2'b00;
  localparam logic [BURST_WIDTH-1:0] BURST_INCR  = 2'b01;

  // write response codes
  localparam logic [RESP_WIDTH-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- source/skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module skid_buffer #(
  parameter type T_DATA     = logic [7:0],
  parameter bit  OUTPUT_REG = 1'b0
) (
  input  wire        clk,
  input  wire        i_reset,
  input  wire        i_valid,
  input  wire T_DATA i_data,
  output logic       o_ready,
  output logic       o_valid,
  output T_DATA      o_data,
  input  wire        i_ready
);

  logic  main_valid;
  logic  spill_valid;
  T_DATA main_data;
  T_DATA spill_data;
  logic  in_fire;
  logic  out_fire;

  // ready only looks at the spill register
  assign o_ready  = !spill_valid;
  assign in_fire  = i_valid && o_ready;
  assign out_fire = o_valid && i_ready;

  if (OUTPUT_REG) begin : gen_out_reg
    // main is the output register, spill waits behind it
    assign o_valid = main_valid;
    assign o_data  = main_data;

    always_ff @(posedge clk) begin
      if (i_reset) begin
        main_valid  <= 1'b0;
        spill_valid <= 1'b0;
      end else if (!main_valid || out_fire) begin
        main_valid  <= spill_valid || in_fire;
        spill_valid <= 1'b0;
      end else if (in_fire) begin
        spill_valid <= 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (!main_valid || out_fire) begin
        main_data <= spill_valid ? spill_data : i_data;
      end
      if (in_fire && main_valid && !out_fire) begin
        spill_data <= i_data;
      end
    end
  end else begin : gen_in_reg
    // main takes every new beat, an older unsent beat moves to spill
    assign o_valid = main_valid || spill_valid;
    assign o_data  = spill_valid ? spill_data : main_data;

    always_ff @(posedge clk) begin
      if (i_reset) begin
        main_valid  <= 1'b0;
        spill_valid <= 1'b0;
      end else if (in_fire) begin
        main_valid  <= 1'b1;
        spill_valid <= main_valid && !out_fire;
      end else if (out_fire) begin
        if (spill_valid) begin
          spill_valid <= 1'b0;
        end else begin
          main_valid <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (in_fire) begin
        main_data  <= i_data;
        spill_data <= main_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/grant_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module grant_arbiter #(
  parameter int NUM_M = 2
) (
  input  wire                       clk,
  input  wire                       i_reset,
  input  wire  [NUM_M-1:0]          i_request,
  input  wire                       i_done,
  output logic                      o_grant_valid,
  output logic [$clog2(NUM_M)-1:0]  o_grant_idx
);

  localparam int IDX_WIDTH = $clog2(NUM_M);

  logic [IDX_WIDTH-1:0] ptr;
  logic [IDX_WIDTH-1:0] pick_idx;
  logic                 pick_found;
  int                   cand;

  // first requester at or after the priority pointer
  always_comb begin
    pick_idx   = '0;
    pick_found = 1'b0;
    cand       = 0;
    for (int k = 0; k < NUM_M; k++) begin
      cand = (int'(ptr) + k) % NUM_M;
      if (!pick_found && i_request[cand]) begin
        pick_found = 1'b1;
        pick_idx   = IDX_WIDTH'(cand);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_grant_valid <= 1'b0;
      o_grant_idx   <= '0;
      ptr           <= '0;
    end else if (o_grant_valid) begin
      // grant stays until the burst is done
      if (i_done) begin
        o_grant_valid <= 1'b0;
      end
    end else if (pick_found) begin
      o_grant_valid <= 1'b1;
      o_grant_idx   <= pick_idx;
      ptr           <= (pick_idx == IDX_WIDTH'(NUM_M - 1)) ? '0 : pick_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/axi_write_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_arbiter #(
  parameter int NUM_M      = 2,
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4
) (
  input  wire                                              clk,
  input  wire                                              i_reset,

  // manager side, one slice per manager
  input  wire  [NUM_M-1:0]                                 i_s_awvalid,
  input  wire  [NUM_M-1:0][ADDR_WIDTH-1:0]                 i_s_awaddr,
  input  wire  [NUM_M-1:0][ID_WIDTH-1:0]                   i_s_awid,
  input  wire  [NUM_M-1:0][axi_wr_pkg::LEN_WIDTH-1:0]      i_s_awlen,
  input  wire  [NUM_M-1:0][axi_wr_pkg::SIZE_WIDTH-1:0]     i_s_awsize,
  input  wire  [NUM_M-1:0][axi_wr_pkg::BURST_WIDTH-1:0]    i_s_awburst,
  output logic [NUM_M-1:0]                                 o_s_awready,
  input  wire  [NUM_M-1:0]                                 i_s_wvalid,
  input  wire  [NUM_M-1:0][DATA_WIDTH-1:0]                 i_s_wdata,
  input  wire  [NUM_M-1:0][DATA_WIDTH/8-1:0]               i_s_wstrb,
  input  wire  [NUM_M-1:0]                                 i_s_wlast,
  output logic [NUM_M-1:0]                                 o_s_wready,
  output logic [NUM_M-1:0]                                 o_s_bvalid,
  output logic [NUM_M-1:0][ID_WIDTH-1:0]                   o_s_bid,
  output logic [NUM_M-1:0][axi_wr_pkg::RESP_WIDTH-1:0]     o_s_bresp,
  input  wire  [NUM_M-1:0]                                 i_s_bready,

  // subordinate side, ID widened by the manager index
  output logic                                             o_m_awvalid,
  output logic [ADDR_WIDTH-1:0]                            o_m_awaddr,
  output logic [ID_WIDTH+$clog2(NUM_M)-1:0]                o_m_awid,
  output logic [axi_wr_pkg::LEN_WIDTH-1:0]                 o_m_awlen,
  output logic [axi_wr_pkg::SIZE_WIDTH-1:0]                o_m_awsize,
  output logic [axi_wr_pkg::BURST_WIDTH-1:0]               o_m_awburst,
  input  wire                                              i_m_awready,
  output logic                                             o_m_wvalid,
  output logic [DATA_WIDTH-1:0]                            o_m_wdata,
  output logic [DATA_WIDTH/8-1:0]                          o_m_wstrb,
  output logic                                             o_m_wlast,
  input  wire                                              i_m_wready,
  input  wire                                              i_m_bvalid,
  input  wire  [ID_WIDTH+$clog2(NUM_M)-1:0]                i_m_bid,
  input  wire  [axi_wr_pkg::RESP_WIDTH-1:0]                i_m_bresp,
  output logic                                             o_m_bready
);

  import axi_wr_pkg::*;

  localparam int IDX_WIDTH  = $clog2(NUM_M);
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  typedef struct packed {
    logic [ID_WIDTH-1:0]    id;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [LEN_WIDTH-1:0]   len;
    logic [SIZE_WIDTH-1:0]  size;
    logic [BURST_WIDTH-1:0] burst;
  } aw_beat_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } w_beat_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [RESP_WIDTH-1:0] resp;
  } b_beat_t;

  aw_beat_t             sb_aw [NUM_M];
  w_beat_t              sb_w [NUM_M];
  b_beat_t              sb_b [NUM_M];
  logic [NUM_M-1:0]     sb_awvalid;
  logic [NUM_M-1:0]     sb_awready;
  logic [NUM_M-1:0]     sb_wvalid;
  logic [NUM_M-1:0]     sb_wready;
  logic [NUM_M-1:0]     sb_bready;
  logic [NUM_M-1:0]     request_mask;
  logic                 grant_valid;
  logic [IDX_WIDTH-1:0] grant_idx;
  logic                 aw_sent;
  logic                 burst_done;
  logic [IDX_WIDTH-1:0] b_idx;
  logic [ID_WIDTH-1:0]  b_id;

  // --------------------------------------------------
  // per manager buffers
  // --------------------------------------------------
  for (genvar i = 0; i < NUM_M; i++) begin : gen_mgr
    skid_buffer #(
      .T_DATA     (aw_beat_t),
      .OUTPUT_REG (1'b0)
    ) u_aw_skid (
      .clk     (clk),
      .i_reset (i_reset),
      .i_valid (i_s_awvalid[i]),
      .i_data  ({i_s_awid[i], i_s_awaddr[i], i_s_awlen[i], i_s_awsize[i], i_s_awburst[i]}),
      .o_ready (o_s_awready[i]),
      .o_valid (sb_awvalid[i]),
      .o_data  (sb_aw[i]),
      .i_ready (sb_awready[i])
    );

    skid_buffer #(
      .T_DATA     (w_beat_t),
      .OUTPUT_REG (1'b0)
    ) u_w_skid (
      .clk     (clk),
      .i_reset (i_reset),
      .i_valid (i_s_wvalid[i]),
      .i_data  ({i_s_wdata[i], i_s_wstrb[i], i_s_wlast[i]}),
      .o_ready (o_s_wready[i]),
      .o_valid (sb_wvalid[i]),
      .o_data  (sb_w[i]),
      .i_ready (sb_wready[i])
    );

    // the B buffer also does the response demux
    skid_buffer #(
      .T_DATA     (b_beat_t),
      .OUTPUT_REG (1'b1)
    ) u_b_skid (
      .clk     (clk),
      .i_reset (i_reset),
      .i_valid (i_m_bvalid && (b_idx == IDX_WIDTH'(i))),
      .i_data  ({b_id, i_m_bresp}),
      .o_ready (sb_bready[i]),
      .o_valid (o_s_bvalid[i]),
      .o_data  (sb_b[i]),
      .i_ready (i_s_bready[i])
    );

    assign o_s_bid[i]   = sb_b[i].id;
    assign o_s_bresp[i] = sb_b[i].resp;
  end

  // --------------------------------------------------
  // arbitration, one grant per burst
  // --------------------------------------------------
  always_comb begin
    request_mask = '1;
    if (grant_valid) begin
      request_mask[grant_idx] = 1'b0;
    end
  end

  assign burst_done = o_m_wvalid && i_m_wready && o_m_wlast;

  grant_arbiter #(
    .NUM_M (NUM_M)
  ) u_grant_arbiter (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_request     (sb_awvalid & request_mask),
    .i_done        (burst_done),
    .o_grant_valid (grant_valid),
    .o_grant_idx   (grant_idx)
  );

  // only one AW per grant
  always_ff @(posedge clk) begin
    if (i_reset) begin
      aw_sent <= 1'b0;
    end else if (burst_done) begin
      aw_sent <= 1'b0;
    end else if (o_m_awvalid && i_m_awready) begin
      aw_sent <= 1'b1;
    end
  end

  // AW and W muxes toward the subordinate
  assign o_m_awvalid = grant_valid && !aw_sent && sb_awvalid[grant_idx];
  assign o_m_awid    = {grant_idx, sb_aw[grant_idx].id};
  assign o_m_awaddr  = sb_aw[grant_idx].addr;
  assign o_m_awlen   = sb_aw[grant_idx].len;
  assign o_m_awsize  = sb_aw[grant_idx].size;
  assign o_m_awburst = sb_aw[grant_idx].burst;

  assign o_m_wvalid = grant_valid && sb_wvalid[grant_idx];
  assign o_m_wdata  = sb_w[grant_idx].data;
  assign o_m_wstrb  = sb_w[grant_idx].strb;
  assign o_m_wlast  = sb_w[grant_idx].last;

  // ready goes back to the grantee only
  always_comb begin
    sb_awready = '0;
    sb_wready  = '0;
    if (grant_valid) begin
      sb_awready[grant_idx] = i_m_awready && !aw_sent;
      sb_wready[grant_idx]  = i_m_wready;
    end
  end

  // --------------------------------------------------
  // write responses
  // --------------------------------------------------
  assign {b_idx, b_id} = i_m_bid;
  assign o_m_bready    = i_m_bvalid && sb_bready[b_idx];

endmodule

`default_nettype wire

//--- source/axi_write_memory.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_memory #(
  parameter int ADDR_WIDTH   = 8,
  parameter int DATA_WIDTH   = 32,
  parameter int SUB_ID_WIDTH = 5,
  parameter int MEM_WORDS    = 48
) (
  input  wire                                 clk,
  input  wire                                 i_reset,
  input  wire                                 i_awvalid,
  input  wire  [ADDR_WIDTH-1:0]               i_awaddr,
  input  wire  [SUB_ID_WIDTH-1:0]             i_awid,
  input  wire  [axi_wr_pkg::LEN_WIDTH-1:0]    i_awlen,
  input  wire  [axi_wr_pkg::SIZE_WIDTH-1:0]   i_awsize,
  input  wire  [axi_wr_pkg::BURST_WIDTH-1:0]  i_awburst,
  output logic                                o_awready,
  input  wire                                 i_wvalid,
  input  wire  [DATA_WIDTH-1:0]               i_wdata,
  input  wire  [DATA_WIDTH/8-1:0]             i_wstrb,
  input  wire                                 i_wlast,
  output logic                                o_wready,
  output logic                                o_bvalid,
  output logic [SUB_ID_WIDTH-1:0]             o_bid,
  output logic [axi_wr_pkg::RESP_WIDTH-1:0]   o_bresp,
  input  wire                                 i_bready,
  input  wire  [$clog2(MEM_WORDS)-1:0]        i_rd_addr,
  output logic [DATA_WIDTH-1:0]               o_rd_data
);

  import axi_wr_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int OFFS_WIDTH = $clog2(STRB_WIDTH);
  localparam int WORD_WIDTH = ADDR_WIDTH - OFFS_WIDTH;
  localparam int SPAN_WIDTH = WORD_WIDTH + LEN_WIDTH;
  localparam logic [SIZE_WIDTH-1:0] FULL_SIZE = SIZE_WIDTH'(OFFS_WIDTH);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_RESP
  } state_t;

  state_t                state;
  state_t                next_state;
  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
  logic [WORD_WIDTH-1:0] start_word;
  logic [WORD_WIDTH-1:0] word_addr;
  logic [SPAN_WIDTH-1:0] last_word;
  logic                  burst_fixed;
  logic                  burst_err;
  logic                  aw_fire;
  logic                  w_fire;

  assign aw_fire    = i_awvalid && o_awready;
  assign w_fire     = i_wvalid && o_wready;
  assign start_word = i_awaddr[ADDR_WIDTH-1:OFFS_WIDTH];

  // last word touched, a FIXED burst stays on its start word
  always_comb begin
    last_word = SPAN_WIDTH'(start_word);
    if (i_awburst == BURST_INCR) begin
      last_word = last_word + SPAN_WIDTH'(i_awlen);
    end
  end

  // --------------------------------------------------
  // burst controller
  // --------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (aw_fire) begin
          next_state = ST_DATA;
        end
      end
      ST_DATA: begin
        if (w_fire && i_wlast) begin
          next_state = ST_RESP;
        end
      end
      default: begin
        if (i_bready) begin
          next_state = ST_IDLE;
        end
      end
    endcase
  end

  // handshake outputs are registered decodes of the next state
  always_ff @(posedge clk) begin
    if (i_reset) begin
      state     <= ST_IDLE;
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
    end else begin
      state     <= next_state;
      o_awready <= (next_state == ST_IDLE);
      o_wready  <= (next_state == ST_DATA);
      o_bvalid  <= (next_state == ST_RESP);
    end
  end

  // range and type check happen once, at address accept
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      o_bid       <= i_awid;
      word_addr   <= start_word;
      burst_fixed <= (i_awburst == BURST_FIXED);
      burst_err   <= (last_word >= SPAN_WIDTH'(MEM_WORDS)) || (i_awsize != FULL_SIZE) ||
                     (i_awburst != BURST_INCR && i_awburst != BURST_FIXED);
    end else if (w_fire && !burst_fixed) begin
      word_addr <= word_addr + 1'b1;
    end
  end

  assign o_bresp = burst_err ? RESP_SLVERR : RESP_OKAY;

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (w_fire && !burst_err) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (i_wstrb[b]) begin
          mem[word_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

`default_nettype wire

//--- source/axi_write_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_subsystem #(
  parameter int NUM_M      = 2,
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int MEM_WORDS  = 48
) (
  input  wire                                              clk,
  input  wire                                              i_reset,
  input  wire  [NUM_M-1:0]                                 i_s_awvalid,
  input  wire  [NUM_M-1:0][ADDR_WIDTH-1:0]                 i_s_awaddr,
  input  wire  [NUM_M-1:0][ID_WIDTH-1:0]                   i_s_awid,
  input  wire  [NUM_M-1:0][axi_wr_pkg::LEN_WIDTH-1:0]      i_s_awlen,
  input  wire  [NUM_M-1:0][axi_wr_pkg::SIZE_WIDTH-1:0]     i_s_awsize,
  input  wire  [NUM_M-1:0][axi_wr_pkg::BURST_WIDTH-1:0]    i_s_awburst,
  output logic [NUM_M-1:0]                                 o_s_awready,
  input  wire  [NUM_M-1:0]                                 i_s_wvalid,
  input  wire  [NUM_M-1:0][DATA_WIDTH-1:0]                 i_s_wdata,
  input  wire  [NUM_M-1:0][DATA_WIDTH/8-1:0]               i_s_wstrb,
  input  wire  [NUM_M-1:0]                                 i_s_wlast,
  output logic [NUM_M-1:0]                                 o_s_wready,
  output logic [NUM_M-1:0]                                 o_s_bvalid,
  output logic [NUM_M-1:0][ID_WIDTH-1:0]                   o_s_bid,
  output logic [NUM_M-1:0][axi_wr_pkg::RESP_WIDTH-1:0]     o_s_bresp,
  input  wire  [NUM_M-1:0]                                 i_s_bready,
  // memory inspection port
  input  wire  [$clog2(MEM_WORDS)-1:0]                     i_rd_addr,
  output logic [DATA_WIDTH-1:0]                            o_rd_data
);

  import axi_wr_pkg::*;

  localparam int SUB_ID_WIDTH = ID_WIDTH + $clog2(NUM_M);

  // arbiter to memory
  logic                    m_awvalid;
  logic [ADDR_WIDTH-1:0]   m_awaddr;
  logic [SUB_ID_WIDTH-1:0] m_awid;
  logic [LEN_WIDTH-1:0]    m_awlen;
  logic [SIZE_WIDTH-1:0]   m_awsize;
  logic [BURST_WIDTH-1:0]  m_awburst;
  logic                    m_awready;
  logic                    m_wvalid;
  logic [DATA_WIDTH-1:0]   m_wdata;
  logic [DATA_WIDTH/8-1:0] m_wstrb;
  logic                    m_wlast;
  logic                    m_wready;
  logic                    m_bvalid;
  logic [SUB_ID_WIDTH-1:0] m_bid;
  logic [RESP_WIDTH-1:0]   m_bresp;
  logic                    m_bready;

  axi_write_arbiter #(
    .NUM_M      (NUM_M),
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH)
  ) u_axi_write_arbiter (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_s_awvalid (i_s_awvalid),
    .i_s_awaddr  (i_s_awaddr),
    .i_s_awid    (i_s_awid),
    .i_s_awlen   (i_s_awlen),
    .i_s_awsize  (i_s_awsize),
    .i_s_awburst (i_s_awburst),
    .o_s_awready (o_s_awready),
    .i_s_wvalid  (i_s_wvalid),
    .i_s_wdata   (i_s_wdata),
    .i_s_wstrb   (i_s_wstrb),
    .i_s_wlast   (i_s_wlast),
    .o_s_wready  (o_s_wready),
    .o_s_bvalid  (o_s_bvalid),
    .o_s_bid     (o_s_bid),
    .o_s_bresp   (o_s_bresp),
    .i_s_bready  (i_s_bready),
    .o_m_awvalid (m_awvalid),
    .o_m_awaddr  (m_awaddr),
    .o_m_awid    (m_awid),
    .o_m_awlen   (m_awlen),
    .o_m_awsize  (m_awsize),
    .o_m_awburst (m_awburst),
    .i_m_awready (m_awready),
    .o_m_wvalid  (m_wvalid),
    .o_m_wdata   (m_wdata),
    .o_m_wstrb   (m_wstrb),
    .o_m_wlast   (m_wlast),
    .i_m_wready  (m_wready),
    .i_m_bvalid  (m_bvalid),
    .i_m_bid     (m_bid),
    .i_m_bresp   (m_bresp),
    .o_m_bready  (m_bready)
  );

  axi_write_memory #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .DATA_WIDTH   (DATA_WIDTH),
    .SUB_ID_WIDTH (SUB_ID_WIDTH),
    .MEM_WORDS    (MEM_WORDS)
  ) u_axi_write_memory (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_awvalid (m_awvalid),
    .i_awaddr  (m_awaddr),
    .i_awid    (m_awid),
    .i_awlen   (m_awlen),
    .i_awsize  (m_awsize),
    .i_awburst (m_awburst),
    .o_awready (m_awready),
    .i_wvalid  (m_wvalid),
    .i_wdata   (m_wdata),
    .i_wstrb   (m_wstrb),
    .i_wlast   (m_wlast),
    .o_wready  (m_wready),
    .o_bvalid  (m_bvalid),
    .o_bid     (m_bid),
    .o_bresp   (m_bresp),
    .i_bready  (m_bready),
    .i_rd_addr (i_rd_addr),
    .o_rd_data (o_rd_data)
  );

endmodule

`default_nettype wire

//--- sim/tb_axi_write_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_write_subsystem;

  import axi_wr_pkg::*;

  localparam int NUM_M      = 2;
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH   = 4;
  localparam int MEM_WORDS  = 48;
  localparam int MAX_LINES  = 32;
  localparam logic [SIZE_WIDTH-1:0] FULL_SIZE = SIZE_WIDTH'($clog2(DATA_WIDTH / 8));

  logic                                 clk = 1'b0;
  logic                                 i_reset;
  logic [NUM_M-1:0]                     i_s_awvalid;
  logic [NUM_M-1:0][ADDR_WIDTH-1:0]     i_s_awaddr;
  logic [NUM_M-1:0][ID_WIDTH-1:0]       i_s_awid;
  logic [NUM_M-1:0][LEN_WIDTH-1:0]      i_s_awlen;
  logic [NUM_M-1:0][SIZE_WIDTH-1:0]     i_s_awsize;
  logic [NUM_M-1:0][BURST_WIDTH-1:0]    i_s_awburst;
  logic [NUM_M-1:0]                     o_s_awready;
  logic [NUM_M-1:0]                     i_s_wvalid;
  logic [NUM_M-1:0][DATA_WIDTH-1:0]     i_s_wdata;
  logic [NUM_M-1:0][DATA_WIDTH/8-1:0]   i_s_wstrb;
  logic [NUM_M-1:0]                     i_s_wlast;
  logic [NUM_M-1:0]                     o_s_wready;
  logic [NUM_M-1:0]                     o_s_bvalid;
  logic [NUM_M-1:0][ID_WIDTH-1:0]       o_s_bid;
  logic [NUM_M-1:0][RESP_WIDTH-1:0]     o_s_bresp;
  logic [NUM_M-1:0]                     i_s_bready;
  logic [$clog2(MEM_WORDS)-1:0]         i_rd_addr;
  logic [DATA_WIDTH-1:0]                o_rd_data;

  // stimulus table with one entry per burst
  int st_mgr [MAX_LINES];
  int st_id [MAX_LINES];
  int st_addr [MAX_LINES];
  int st_len [MAX_LINES];
  int st_burst [MAX_LINES];
  int st_strb [MAX_LINES];
  int st_resp [MAX_LINES];
  int num_lines;
  int total_beats;
  int lines_per_mgr [NUM_M];
  bit loaded;

  // expected responses per manager in issue order
  int exp_id [NUM_M][MAX_LINES];
  int exp_resp [NUM_M][MAX_LINES];
  int issued [NUM_M];
  int answered [NUM_M];

  logic [DATA_WIDTH-1:0] model_mem [MEM_WORDS];
  logic [31:0]           lfsr_state = 32'h2cfa_e52a;
  int                    aw_left [NUM_M];
  int                    aw_mgr;
  int                    last_aw_mgr = -1;
  int                    m1_done_during_stall;
  int                    value_errors;
  int                    other_errors;

  always #10 clk = ~clk;

  axi_write_subsystem #(
    .NUM_M      (NUM_M),
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MEM_WORDS  (MEM_WORDS)
  ) u_axi_write_subsystem (.*);

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // ready is sampled mid cycle and the beat moves on the next rising edge
  task automatic wait_handshake(input int m, input bit is_w);
    bit fire;
    fire = 1'b0;
    while (!fire) begin
      @(negedge clk);
      fire = is_w ? o_s_wready[m] : o_s_awready[m];
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_burst(input int m, input int n);
    int                    word;
    logic [7:0]            rot;
    logic [3:0]            strb;
    logic [DATA_WIDTH-1:0] data;
    i_s_awvalid[m] = 1'b1;
    i_s_awid[m]    = ID_WIDTH'(st_id[n]);
    i_s_awaddr[m]  = ADDR_WIDTH'(st_addr[n]);
    i_s_awlen[m]   = LEN_WIDTH'(st_len[n]);
    i_s_awsize[m]  = FULL_SIZE;
    i_s_awburst[m] = BURST_WIDTH'(st_burst[n]);
    wait_handshake(m, 1'b0);
    i_s_awvalid[m] = 1'b0;
    exp_id[m][issued[m]]   = st_id[n];
    exp_resp[m][issued[m]] = st_resp[n];
    issued[m]++;
    word = st_addr[n] / 4;
    for (int beat = 0; beat <= st_len[n]; beat++) begin
      // strobe pattern rotates left by one byte lane per beat
      rot  = {st_strb[n][3:0], st_strb[n][3:0]} << (beat % 4);
      strb = rot[7:4];
      data = random_bits(DATA_WIDTH);
      i_s_wvalid[m] = 1'b1;
      i_s_wdata[m]  = data;
      i_s_wstrb[m]  = strb;
      i_s_wlast[m]  = (beat == st_len[n]);
      wait_handshake(m, 1'b1);
      if (st_resp[n] == int'(RESP_OKAY)) begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            model_mem[word][b*8 +: 8] = data[b*8 +: 8];
          end
        end
      end
      if (st_burst[n] == int'(BURST_INCR)) begin
        word++;
      end
    end
    i_s_wvalid[m] = 1'b0;
    i_s_wlast[m]  = 1'b0;
  endtask

  task automatic run_manager(input int m);
    for (int n = 0; n < num_lines; n++) begin
      if (st_mgr[n] == m) begin
        send_burst(m, n);
      end
    end
  endtask

  // manager 0 holds bready low for random stretches
  task automatic stall_bready();
    forever begin
      i_s_bready[0] = 1'b0;
      repeat (random_bits(4) + 4) @(posedge clk);
      #1;
      i_s_bready[0] = 1'b1;
      repeat (random_bits(2) + 1) @(posedge clk);
      #1;
    end
  endtask

  // --------------------------------------------------
  // response and grant order monitors
  // --------------------------------------------------
  always @(negedge clk) begin
    if (!i_reset) begin
      for (int m = 0; m < NUM_M; m++) begin
        if (o_s_bvalid[m] && i_s_bready[m]) begin
          if (answered[m] >= issued[m]) begin
            other_errors++;
            $display("manager %0d received a write response it never issued", m);
          end else begin
            check_value($sformatf("o_s_bid[%0d]", m), o_s_bid[m], exp_id[m][answered[m]]);
            check_value($sformatf("o_s_bresp[%0d]", m), o_s_bresp[m],
                        exp_resp[m][answered[m]]);
            answered[m]++;
          end
        end
      end
      if (o_s_bvalid[1] && i_s_bready[1] && o_s_bvalid[0] && !i_s_bready[0]) begin
        m1_done_during_stall++;
      end
      // bursts enter the memory in grant order between the two managers
      if (u_axi_write_subsystem.m_awvalid && u_axi_write_subsystem.m_awready) begin
        aw_mgr = int'(u_axi_write_subsystem.m_awid >> ID_WIDTH);
        if (aw_mgr == last_aw_mgr && aw_left[1 - aw_mgr] > 0) begin
          other_errors++;
          $display("round robin broken, manager %0d granted twice while manager %0d waited",
                   aw_mgr, 1 - aw_mgr);
        end
        aw_left[aw_mgr]--;
        last_aw_mgr = aw_mgr;
      end
    end
  end

  initial begin
    int limit;
    wait (loaded);
    limit = total_beats * 20 + 300;
    repeat (limit) @(posedge clk);
    $display("timeout, the writes did not complete within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int    fd;
    int    rc;
    string line;
    i_reset     = 1'b1;
    i_s_awvalid = '0;
    i_s_awaddr  = '0;
    i_s_awid    = '0;
    i_s_awlen   = '0;
    i_s_awsize  = '0;
    i_s_awburst = '0;
    i_s_wvalid  = '0;
    i_s_wdata   = '0;
    i_s_wstrb   = '0;
    i_s_wlast   = '0;
    i_s_bready  = '1;
    i_rd_addr   = '0;
    fd = $fopen("sim/stimulus_writes.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("cannot open the stimulus file sim/stimulus_writes.txt");
    end else begin
      while (!$feof(fd) && num_lines < MAX_LINES) begin
        rc = $fgets(line, fd);
        if (rc > 0 && line.len() > 1 && line[0] != "#") begin
          rc = $sscanf(line, "%d %h %h %d %d %h %h", st_mgr[num_lines], st_id[num_lines],
                       st_addr[num_lines], st_len[num_lines], st_burst[num_lines],
                       st_strb[num_lines], st_resp[num_lines]);
          if (rc == 7) begin
            lines_per_mgr[st_mgr[num_lines]]++;
            total_beats += st_len[num_lines] + 1;
            num_lines++;
          end
        end
      end
      $fclose(fd);
    end
    aw_left = lines_per_mgr;
    loaded  = 1'b1;

    repeat (3) @(posedge clk);
    #1;
    i_reset = 1'b0;
    fork
      run_manager(0);
      run_manager(1);
      stall_bready();
    join_none
    while (answered[0] < lines_per_mgr[0] || answered[1] < lines_per_mgr[1]) begin
      @(posedge clk);
    end
    #1;

    // read back every word including untouched ones
    for (int w = 0; w < MEM_WORDS; w++) begin
      i_rd_addr = w;
      @(posedge clk);
      @(negedge clk);
      check_value($sformatf("o_rd_data[word %0d]", w), o_rd_data, model_mem[w]);
      @(posedge clk);
      #1;
    end
    if (m1_done_during_stall == 0) begin
      other_errors++;
      $display("manager 1 completed no write while manager 0 held its response");
    end

    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/stimulus_writes.txt
# manager id(hex) addr(hex byte) len burst(0 FIXED, 1 INCR) strobe(hex) resp(hex, 0 OKAY, 2 SLVERR)
# strobe rotates left by one byte lane per beat, manager 0 uses words 0-23, manager 1 words 24-47
0 3 00 3 1 f 0
1 2 60 3 1 f 0
0 5 10 1 1 3 0
1 4 70 0 0 5 0
0 a 18 3 0 3 0
1 9 b0 7 1 f 2
0 c 20 2 1 0 0
1 e 80 2 0 f 0
0 1 f0 0 1 f 2
1 6 88 5 1 9 0
0 7 30 4 1 e 0
1 b a0 1 1 c 0

//--- verilog.f
source/axi_wr_pkg.sv
source/skid_buffer.sv
source/grant_arbiter.sv
source/axi_write_arbiter.sv
source/axi_write_memory.sv
source/axi_write_subsystem.sv
sim/tb_axi_write_subsystem.sv

//--- Bender.yml
package:
  name: axi_write_subsystem

dependencies: {}

sources:
  - files:
      - source/axi_wr_pkg.sv
      - source/skid_buffer.sv
      - source/grant_arbiter.sv
      - source/axi_write_arbiter.sv
      - source/axi_write_memory.sv
      - source/axi_write_subsystem.sv
  - target: simulation
    files:
      - sim/tb_axi_write_subsystem.sv
